//--- hdl/ice51_pkg.sv
package ice51_pkg;

   //////////////////////////////
   // sizes and bit timing

   localparam int CODE_AW    = 10;
   localparam int CODE_DEPTH = 1024;    // bytes taken by the boot loader
   localparam int BAUD_DIV   = 104;     // one bit is BAUD_DIV+1 clocks
   localparam int BAUD_W     = $clog2(BAUD_DIV + 1);

   typedef logic [7:0]         byte_t;
   typedef logic [CODE_AW-1:0] code_addr_t;

   // movx targets on the data pointer
   localparam logic [15:0] TX_STAT_ADDR = 16'h0200;
   localparam logic [15:0] TX_DATA_ADDR = 16'h0201;

   //////////////////////////////
   // opcodes, 8051 encoding

   localparam byte_t OP_NOP    = 8'h00;
   localparam byte_t OP_LJMP   = 8'h02;
   localparam byte_t OP_INCA   = 8'h04;
   localparam byte_t OP_DECA   = 8'h14;
   localparam byte_t OP_ADDAI  = 8'h24;
   localparam byte_t OP_ORLAI  = 8'h44;
   localparam byte_t OP_ANLAI  = 8'h54;
   localparam byte_t OP_JZ     = 8'h60;
   localparam byte_t OP_XRLAI  = 8'h64;
   localparam byte_t OP_JNZ    = 8'h70;
   localparam byte_t OP_MOVAI  = 8'h74;
   localparam byte_t OP_SJMP   = 8'h80;
   localparam byte_t OP_MOVDP  = 8'h90;
   localparam byte_t OP_SUBBAI = 8'h94;
   localparam byte_t OP_CLRC   = 8'hC3;
   localparam byte_t OP_SETBC  = 8'hD3;
   localparam byte_t OP_MOVXAD = 8'hE0;   // movx a,@dptr
   localparam byte_t OP_CLRA   = 8'hE4;
   localparam byte_t OP_MOVXDA = 8'hF0;   // movx @dptr,a
   localparam byte_t OP_CPLA   = 8'hF4;

   typedef enum logic [2:0] {
      ST_FETCH   = 3'd0,
      ST_DECODE0 = 3'd1,
      ST_DECODE1 = 3'd2,
      ST_DECODE2 = 3'd3,
      ST_EXECUTE = 3'd4
   } cpu_state_e;

   // one instruction on its way to the execute units
   typedef struct packed {
      logic       ljmp;
      logic       sjmp;
      logic       jz;
      logic       jnz;
      logic       movdp;
      logic       movxda;
      logic       movxad;
      logic       inca;
      logic       deca;
      logic       addai;
      logic       subbai;
      logic       anlai;
      logic       orlai;
      logic       xrlai;
      logic       movai;
      logic       clra;
      logic       cpla;
      logic       clrc;
      logic       setbc;
      logic [1:0] len;      // 1, 2 or 3 bytes
      byte_t      h_data;   // byte after the opcode
      byte_t      l_data;   // third byte
   } decode_t;

endpackage

//--- hdl/code_loader.sv
`timescale 1ns/10ps

module code_loader import ice51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_uart_rx,
   input  code_addr_t i_fetch_addr,
   output logic       o_load_done,
   output logic       o_code_wr,
   output code_addr_t o_code_addr,
   output byte_t      o_code_data
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e         rx_state;
   logic              rx_meta;
   logic              rx_sync;
   logic [BAUD_W-1:0] baud_cnt;
   logic [2:0]        bit_cnt;
   logic              half_bit;
   logic              full_bit;
   logic              byte_done;
   byte_t             rx_byte;
   code_addr_t        load_cnt;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_uart_rx;
         rx_sync <= rx_meta;
      end
   end

   assign half_bit  = (baud_cnt == BAUD_W'(BAUD_DIV / 2));
   assign full_bit  = (baud_cnt == BAUD_W'(BAUD_DIV));
   assign byte_done = (rx_state == RX_STOP) & full_bit;

   //////////////////////////////
   // receive fsm

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_state <= RX_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
         unique case (rx_state)
            RX_IDLE: begin
               baud_cnt <= '0;
               if (!rx_sync) rx_state <= RX_START;
            end
            RX_START: if (half_bit) begin   // middle of start bit
               baud_cnt <= '0;
               bit_cnt  <= '0;
               rx_state <= rx_sync ? RX_IDLE : RX_DATA;   // high again, just a glitch
            end
            RX_DATA: if (full_bit) begin
               baud_cnt <= '0;
               bit_cnt  <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7) rx_state <= RX_STOP;
            end
            RX_STOP: if (full_bit) begin
               baud_cnt <= '0;
               rx_state <= RX_IDLE;
            end
         endcase
      end
   end

   // lsb first
   always_ff @(posedge i_clk) begin
      if ((rx_state == RX_DATA) && full_bit) rx_byte <= {rx_sync, rx_byte[7:1]};
   end

   //////////////////////////////
   // load count and memory side

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         load_cnt    <= '0;
         o_load_done <= 1'b0;
      end else if (o_code_wr) begin
         load_cnt <= load_cnt + 1'b1;
         if (load_cnt == code_addr_t'(CODE_DEPTH - 1)) o_load_done <= 1'b1;
      end
   end

   assign o_code_wr   = byte_done & ~o_load_done;
   assign o_code_data = rx_byte;
   assign o_code_addr = o_load_done ? i_fetch_addr : load_cnt;   // core owns memory after load

   // done only right after a write that wrapped the count over the whole image
   a_done_after_last_wr : assert property (@(posedge i_clk) disable iff (!i_nrst)
      $rose(o_load_done) |-> ($past(o_code_wr) && load_cnt == '0));

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/10ps

module uart_tx import ice51_pkg::*; (
   input  logic  i_clk,
   input  logic  i_nrst,
   input  logic  i_start,
   input  byte_t i_data,
   output logic  o_busy,
   output logic  o_uart_tx
);

   logic [BAUD_W-1:0] baud_cnt;
   logic [3:0]        bit_cnt;
   logic [9:0]        frame;      // stop, data, start
   logic              accept;
   logic              bit_end;

   assign accept  = i_start & ~o_busy;   // start while busy is dropped
   assign bit_end = o_busy & (baud_cnt == BAUD_W'(BAUD_DIV));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_busy   <= 1'b0;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         if (accept) begin
            o_busy  <= 1'b1;
            bit_cnt <= '0;
         end else if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) o_busy <= 1'b0;   // end of stop bit
         end

         if (!o_busy || bit_end) baud_cnt <= '0;
         else                    baud_cnt <= baud_cnt + 1'b1;
      end
   end

   //////////////////////////////
   // shifter

   // ones shift in behind the frame so the idle line sits high
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)      frame <= '1;
      else if (accept)  frame <= {1'b1, i_data, 1'b0};
      else if (bit_end) frame <= {1'b1, frame[9:1]};
   end

   assign o_uart_tx = frame[0];

   // line must be back at mark level whenever the transmitter is free
   a_idle_high : assert property (@(posedge i_clk) disable iff (!i_nrst)
      !o_busy |-> o_uart_tx);

endmodule

//--- hdl/core_fetch.sv
`timescale 1ns/10ps

module core_fetch import ice51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_load_done,
   input  byte_t      i_code_data,
   output cpu_state_e o_state,
   output decode_t    o_dec
);

   cpu_state_e state;
   cpu_state_e state_next;
   byte_t      op_q;
   byte_t      op_cur;
   byte_t      h_q;
   byte_t      l_q;
   decode_t    dec;

   // opcode is still on the bus during decode0
   assign op_cur = (state == ST_DECODE0) ? i_code_data : op_q;

   //////////////////////////////
   // decoder

   always_comb begin
      dec        = '0;
      dec.len    = 2'd1;
      dec.h_data = h_q;
      dec.l_data = l_q;
      case (op_cur)
         OP_NOP    : dec.len = 2'd1;
         OP_LJMP   : begin
            dec.ljmp = 1'b1;
            dec.len  = 2'd3;
         end
         OP_MOVDP  : begin
            dec.movdp = 1'b1;
            dec.len   = 2'd3;
         end
         OP_SJMP   : begin
            dec.sjmp = 1'b1;
            dec.len  = 2'd2;
         end
         OP_JZ     : begin
            dec.jz  = 1'b1;
            dec.len = 2'd2;
         end
         OP_JNZ    : begin
            dec.jnz = 1'b1;
            dec.len = 2'd2;
         end
         OP_ADDAI  : begin
            dec.addai = 1'b1;
            dec.len   = 2'd2;
         end
         OP_SUBBAI : begin
            dec.subbai = 1'b1;
            dec.len    = 2'd2;
         end
         OP_ANLAI  : begin
            dec.anlai = 1'b1;
            dec.len   = 2'd2;
         end
         OP_ORLAI  : begin
            dec.orlai = 1'b1;
            dec.len   = 2'd2;
         end
         OP_XRLAI  : begin
            dec.xrlai = 1'b1;
            dec.len   = 2'd2;
         end
         OP_MOVAI  : begin
            dec.movai = 1'b1;
            dec.len   = 2'd2;
         end
         OP_INCA   : dec.inca   = 1'b1;
         OP_DECA   : dec.deca   = 1'b1;
         OP_CLRA   : dec.clra   = 1'b1;
         OP_CPLA   : dec.cpla   = 1'b1;
         OP_CLRC   : dec.clrc   = 1'b1;
         OP_SETBC  : dec.setbc  = 1'b1;
         OP_MOVXDA : dec.movxda = 1'b1;
         OP_MOVXAD : dec.movxad = 1'b1;
         default   : ;   // anything else runs as a one byte nop
      endcase
   end

   //////////////////////////////
   // state machine

   always_comb begin
      unique case (state)
         ST_FETCH   : state_next = i_load_done ? ST_DECODE0 : ST_FETCH;
         ST_DECODE0 : state_next = (dec.len == 2'd1) ? ST_EXECUTE : ST_DECODE1;
         ST_DECODE1 : state_next = (dec.len == 2'd3) ? ST_DECODE2 : ST_EXECUTE;
         ST_DECODE2 : state_next = ST_EXECUTE;
         default    : state_next = ST_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= ST_FETCH;
         op_q  <= OP_NOP;
      end else begin
         state <= state_next;
         if (state == ST_DECODE0) op_q <= i_code_data;
      end
   end

   // operand bytes
   always_ff @(posedge i_clk) begin
      if (state == ST_DECODE1) h_q <= i_code_data;
      if (state == ST_DECODE2) l_q <= i_code_data;
   end

   assign o_state = state;
   assign o_dec   = dec;

   a_state_legal : assert property (@(posedge i_clk) disable iff (!i_nrst)
      state inside {ST_FETCH, ST_DECODE0, ST_DECODE1, ST_DECODE2, ST_EXECUTE});

endmodule

//--- hdl/core_pc.sv
`timescale 1ns/10ps

module core_pc import ice51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  cpu_state_e i_state,
   input  decode_t    i_dec,
   input  logic       i_acc_zero,
   output code_addr_t o_pc
);

   code_addr_t  pc_next;
   code_addr_t  rel_off;
   logic [15:0] abs_addr;
   logic        taken;

   // pc already points past the instruction when execute comes round
   assign rel_off  = {{(CODE_AW - 8){i_dec.h_data[7]}}, i_dec.h_data};
   assign abs_addr = {i_dec.h_data, i_dec.l_data};

   assign taken = i_dec.sjmp |
                  (i_dec.jz  &  i_acc_zero) |
                  (i_dec.jnz & ~i_acc_zero);

   always_comb begin
      pc_next = o_pc;
      unique case (i_state)
         ST_DECODE0,
         ST_DECODE1,
         ST_DECODE2 : pc_next = o_pc + 1'b1;   // one step per byte read
         ST_EXECUTE : begin
            if (i_dec.ljmp) pc_next = abs_addr[CODE_AW-1:0];   // upper bits dropped
            else if (taken) pc_next = o_pc + rel_off;
         end
         default    : pc_next = o_pc;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) o_pc <= '0;
      else         o_pc <= pc_next;
   end

endmodule

//--- hdl/core_exec.sv
`timescale 1ns/10ps

module core_exec import ice51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  cpu_state_e i_state,
   input  decode_t    i_dec,
   input  logic       i_tx_busy,
   output logic       o_acc_zero,
   output logic       o_tx_start,
   output byte_t      o_tx_data
);

   byte_t       acc;
   byte_t       acc_next;
   byte_t       xdata_rd;
   logic        carry;
   logic        carry_next;
   logic [15:0] dptr;
   logic [8:0]  add_res;
   logic [8:0]  sub_res;
   logic        exec;
   logic        acc_upd;
   logic        carry_upd;

   assign exec = (i_state == ST_EXECUTE);

   //////////////////////////////
   // alu

   assign add_res = {1'b0, acc} + {1'b0, i_dec.h_data};
   assign sub_res = {1'b0, acc} - {1'b0, i_dec.h_data} - {8'd0, carry};   // bit 8 is borrow

   // only the transmitter status lives in xdata
   assign xdata_rd = (dptr == TX_STAT_ADDR) ? {7'd0, i_tx_busy} : 8'h00;

   always_comb begin
      if      (i_dec.movai)  acc_next = i_dec.h_data;
      else if (i_dec.addai)  acc_next = add_res[7:0];
      else if (i_dec.subbai) acc_next = sub_res[7:0];
      else if (i_dec.anlai)  acc_next = acc & i_dec.h_data;
      else if (i_dec.orlai)  acc_next = acc | i_dec.h_data;
      else if (i_dec.xrlai)  acc_next = acc ^ i_dec.h_data;
      else if (i_dec.inca)   acc_next = acc + 8'd1;
      else if (i_dec.deca)   acc_next = acc - 8'd1;
      else if (i_dec.clra)   acc_next = 8'h00;
      else if (i_dec.cpla)   acc_next = ~acc;
      else if (i_dec.movxad) acc_next = xdata_rd;
      else                   acc_next = acc;
   end

   assign acc_upd = exec & (i_dec.movai | i_dec.addai | i_dec.subbai | i_dec.anlai |
                            i_dec.orlai | i_dec.xrlai | i_dec.inca | i_dec.deca |
                            i_dec.clra | i_dec.cpla | i_dec.movxad);

   // inc and dec leave carry alone, as on the 8051
   assign carry_next = (i_dec.addai  & add_res[8]) |
                       (i_dec.subbai & sub_res[8]) |
                        i_dec.setbc;
   assign carry_upd  = exec & (i_dec.addai | i_dec.subbai | i_dec.clrc | i_dec.setbc);

   //////////////////////////////
   // registers

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc        <= 8'h00;
         o_acc_zero <= 1'b1;     // acc starts at zero
         carry      <= 1'b0;
         dptr       <= 16'h0000;
      end else begin
         if (acc_upd) begin
            acc        <= acc_next;
            o_acc_zero <= (acc_next == 8'h00);
         end
         if (carry_upd)              carry <= carry_next;
         if (exec && i_dec.movdp)    dptr  <= {i_dec.h_data, i_dec.l_data};
      end
   end

   // movx @dptr,a to the data port kicks the transmitter
   assign o_tx_start = exec & i_dec.movxda & (dptr == TX_DATA_ADDR);
   assign o_tx_data  = acc;

endmodule

//--- hdl/ice51_top.sv
`timescale 1ns/10ps

module ice51_top import ice51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_uart_rx,
   output logic       o_uart_tx,
   output logic       o_code_wr,
   output code_addr_t o_code_addr,
   output byte_t      o_code_data,
   input  byte_t      i_code_data
);

   logic       load_done;
   code_addr_t pc;
   cpu_state_e state;
   decode_t    dec;
   logic       acc_zero;
   logic       tx_start;
   byte_t      tx_data;
   logic       tx_busy;

   //////////////////////////////
   // boot loader and serial out

   code_loader u_loader (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_uart_rx    (i_uart_rx),
      .i_fetch_addr (pc),
      .o_load_done  (load_done),
      .o_code_wr    (o_code_wr),
      .o_code_addr  (o_code_addr),
      .o_code_data  (o_code_data)
   );

   uart_tx u_tx (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_start   (tx_start),
      .i_data    (tx_data),
      .o_busy    (tx_busy),
      .o_uart_tx (o_uart_tx)
   );

   //////////////////////////////
   // core

   core_fetch u_fetch (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_code_data (i_code_data),
      .o_state     (state),
      .o_dec       (dec)
   );

   core_pc u_pc (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_state    (state),
      .i_dec      (dec),
      .i_acc_zero (acc_zero),
      .o_pc       (pc)
   );

   core_exec u_exec (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_state    (state),
      .i_dec      (dec),
      .i_tx_busy  (tx_busy),
      .o_acc_zero (acc_zero),
      .o_tx_start (tx_start),
      .o_tx_data  (tx_data)
   );

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
   output logic o_clk,
   output logic o_nrst
);

   initial begin
      o_clk = 1'b0;
      forever #5 o_clk = ~o_clk;   // 10 ns period
   end

   // reset held over 8 rising edges, released on a falling one
   initial begin
      o_nrst = 1'b0;
      repeat (8) @(posedge o_clk);
      @(negedge o_clk);
      o_nrst = 1'b1;
   end

endmodule

//--- tb/tb_ice51.sv
`timescale 1ns/10ps

module tb_ice51 import ice51_pkg::*; ();

   logic        clk;
   logic        nrst;
   logic        rx_line;
   logic        tx_line;
   logic        code_wr;
   code_addr_t  code_addr;
   byte_t       code_wdata;
   byte_t       code_rdata;
   byte_t       mem [CODE_DEPTH];
   byte_t       image [CODE_DEPTH];
   byte_t       exp_q [$];
   logic [31:0] lfsr;
   logic        in_frame;
   int          wp;
   int          wr_cnt;
   int          rx_count;
   int          errors;
   int          cycle_limit;
   int          cycles;

   tb_clk_gen u_clk_gen (.o_clk(clk), .o_nrst(nrst));

   ice51_top dut (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_uart_rx   (rx_line),
      .o_uart_tx   (tx_line),
      .o_code_wr   (code_wr),
      .o_code_addr (code_addr),
      .o_code_data (code_wdata),
      .i_code_data (code_rdata)
   );

   //////////////////////////////
   // code memory model

   assign code_rdata = mem[code_addr];   // combinational read

   always @(posedge clk) begin
      if (code_wr) mem[code_addr] <= code_wdata;
   end

   always @(posedge clk or negedge nrst) begin
      if (!nrst)        wr_cnt <= 0;
      else if (code_wr) wr_cnt <= wr_cnt + 1;
   end

   //////////////////////////////
   // helpers

   task automatic log_error(input string msg);
      errors++;
      $display("Fail %0t: %s", $time, msg);
   endtask

   // taps 32,22,2,1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic byte_t rand_byte();
      byte_t v;
      v = 8'h00;
      for (int k = 0; k < 8; k++) begin
         lfsr = lfsr_step(lfsr);   // one step per bit
         v    = {v[6:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic emit(input byte_t b);
      image[wp] = b;
      wp++;
   endtask

   task automatic emit2(input byte_t op, input byte_t h);
      emit(op);
      emit(h);
   endtask

   task automatic emit3(input byte_t op, input byte_t h, input byte_t l);
      emit2(op, h);
      emit(l);
   endtask

   // spin on the status port until the transmitter is idle
   task automatic emit_poll();
      emit3(OP_MOVDP, TX_STAT_ADDR[15:8], TX_STAT_ADDR[7:0]);
      emit(OP_MOVXAD);
      emit2(OP_JNZ, 8'hFA);   // back 6 to mov dptr
   endtask

   task automatic emit_send();
      emit3(OP_MOVDP, TX_DATA_ADDR[15:8], TX_DATA_ADDR[7:0]);
      emit(OP_MOVXDA);
   endtask

   task automatic emit_alu_test(input byte_t op, input byte_t a, input byte_t b);
      emit_poll();
      emit2(OP_MOVAI, a);
      emit2(op, b);
      emit_send();
   endtask

   task automatic build_program();
      int halt_at;
      int far;
      for (int i = 0; i < CODE_DEPTH; i++) image[i] = 8'h00;   // zero padding
      wp = 0;
      emit3(OP_LJMP, 8'h00, 8'h10);
      wp = 16;
      emit_alu_test(OP_ADDAI, rand_byte(), rand_byte());
      emit_alu_test(OP_ANLAI, rand_byte(), rand_byte());
      emit_alu_test(OP_ORLAI, rand_byte(), rand_byte());
      emit_alu_test(OP_XRLAI, rand_byte(), rand_byte());
      emit_poll();
      emit2(OP_MOVAI, 8'hF0);
      emit2(OP_ADDAI, 8'h20);                // carry out
      emit2(OP_SUBBAI, rand_byte());         // and borrowed back in
      emit_send();
      emit_poll();
      emit(OP_SETBC);
      emit_alu_test(OP_SUBBAI, rand_byte(), rand_byte());
      emit_poll();
      emit(OP_CLRC);
      emit_alu_test(OP_SUBBAI, rand_byte(), rand_byte());
      emit_poll();
      emit2(OP_MOVAI, rand_byte());
      emit(OP_CPLA);
      emit(OP_INCA);
      emit_send();
      emit_poll();
      emit(OP_CLRA);
      emit(OP_DECA);
      emit_send();
      // countdown, then a forward jz over a decoy load
      emit_poll();
      emit2(OP_MOVAI, 8'h07);
      emit(OP_DECA);
      emit2(OP_JNZ, 8'hFD);
      emit2(OP_JZ, 8'h02);
      emit2(OP_MOVAI, 8'h55);
      emit2(OP_ADDAI, rand_byte());
      emit_send();
      halt_at = wp + 3;
      far     = halt_at + 18;
      emit3(OP_LJMP, 8'(far >> 8), 8'(far));
      emit2(OP_SJMP, 8'hFE);                 // parked here at the end
      wp = far;
      emit_poll();
      emit2(OP_MOVAI, 8'h3C);
      emit_send();
      emit2(OP_SJMP, 8'(halt_at - (wp + 2)));   // backward to the halt
   endtask

   //////////////////////////////
   // reference model, untimed

   task automatic run_model();
      int          pc;
      int          nxt;
      int          tmp;
      int          steps;
      byte_t       op;
      byte_t       h;
      byte_t       l;
      byte_t       acc;
      logic        cy;
      logic        halted;
      logic [15:0] dp;
      pc     = 0;
      acc    = 8'h00;
      cy     = 1'b0;
      dp     = 16'h0000;
      halted = 1'b0;
      steps  = 0;
      while (!halted && steps < 20000) begin
         op = image[pc];
         h  = image[(pc + 1) % CODE_DEPTH];
         l  = image[(pc + 2) % CODE_DEPTH];
         steps++;
         if (op inside {OP_LJMP, OP_MOVDP}) nxt = pc + 3;
         else if (op inside {OP_SJMP, OP_JZ, OP_JNZ, OP_ADDAI, OP_SUBBAI, OP_ANLAI,
                             OP_ORLAI, OP_XRLAI, OP_MOVAI}) nxt = pc + 2;
         else nxt = pc + 1;
         case (op)
            OP_LJMP   : nxt = int'({h, l});
            OP_SJMP   : begin
               nxt    = nxt + int'($signed(h));
               halted = (h == 8'hFE);
            end
            OP_JZ     : if (acc == 8'h00) nxt = nxt + int'($signed(h));
            OP_JNZ    : if (acc != 8'h00) nxt = nxt + int'($signed(h));
            OP_MOVDP  : dp = {h, l};
            OP_MOVXDA : if (dp == TX_DATA_ADDR) exp_q.push_back(acc);
            OP_MOVXAD : acc = 8'h00;   // transmitter seen as idle
            OP_MOVAI  : acc = h;
            OP_ADDAI  : begin
               tmp = int'(acc) + int'(h);
               cy  = (tmp > 255);
               acc = 8'(tmp);
            end
            OP_SUBBAI : begin
               tmp = int'(acc) - int'(h) - int'(cy);
               cy  = (tmp < 0);
               acc = 8'(tmp);
            end
            OP_ANLAI  : acc = acc & h;
            OP_ORLAI  : acc = acc | h;
            OP_XRLAI  : acc = acc ^ h;
            OP_INCA   : acc = acc + 8'd1;
            OP_DECA   : acc = acc - 8'd1;
            OP_CLRA   : acc = 8'h00;
            OP_CPLA   : acc = ~acc;
            OP_CLRC   : cy = 1'b0;
            OP_SETBC  : cy = 1'b1;
            default   : ;
         endcase
         pc = nxt & (CODE_DEPTH - 1);
      end
   endtask

   task automatic send_uart_byte(input byte_t b);
      logic [9:0] bits;
      bits = {1'b1, b, 1'b0};
      for (int k = 0; k < 10; k++) begin
         @(negedge clk);
         rx_line = bits[k];
         repeat (BAUD_DIV) @(negedge clk);
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d, bytes loaded: %0d, bytes sent back: %0d of %0d",
               errors, wr_cnt, rx_count, exp_q.size());
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   endtask

   //////////////////////////////
   // checks

   a_wr_in_order : assert property (@(posedge clk) disable iff (!nrst)
      code_wr |-> (wr_cnt < CODE_DEPTH && code_addr == code_addr_t'(wr_cnt) &&
                   code_wdata == image[wr_cnt]))
      else log_error("loader wrote the wrong address or byte, or wrote too many");

   a_loader_owns_addr : assert property (@(posedge clk) disable iff (!nrst)
      (wr_cnt < CODE_DEPTH) |-> (code_addr == code_addr_t'(wr_cnt)))
      else log_error("foreign address on the code bus during load");

   a_first_fetch : assert property (@(posedge clk) disable iff (!nrst)
      (code_wr && wr_cnt == CODE_DEPTH - 1) |=> (code_addr == '0))
      else log_error("first fetch address after load is not 0");

   a_line_idle : assert property (@(posedge clk) disable iff (!nrst)
      !in_frame |-> tx_line)
      else log_error("tx line low between frames");

   //////////////////////////////
   // uart monitor, mid-bit sampling

   initial begin : tx_monitor
      byte_t got;
      in_frame = 1'b0;
      rx_count = 0;
      wait (nrst === 1'b1);
      forever begin
         @(negedge tx_line);
         in_frame = 1'b1;
         repeat ((BAUD_DIV + 1) / 2) @(negedge clk);
         a_start_bit : assert (tx_line == 1'b0) else log_error("start bit too short");
         for (int k = 0; k < 8; k++) begin
            repeat (BAUD_DIV + 1) @(negedge clk);
            got = {tx_line, got[7:1]};   // lsb first
         end
         repeat (BAUD_DIV + 1) @(negedge clk);
         a_stop_bit : assert (tx_line == 1'b1) else log_error("stop bit missing");
         a_tx_byte : assert (rx_count < exp_q.size() && got == exp_q[rx_count])
            else log_error($sformatf("tx byte %0d is %02h", rx_count, got));
         rx_count++;
         in_frame = 1'b0;
      end
   end

   initial begin : watchdog
      cycles = 0;
      wait (cycle_limit > 0);
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      errors++;
      $display("timeout after %0d cycles, the program never finished sending", cycles);
      finish_run();
   end

   initial begin : main
      rx_line     = 1'b1;
      errors      = 0;
      cycle_limit = 0;
      lfsr        = 32'h3b9f;
      for (int i = 0; i < CODE_DEPTH; i++) mem[i] = 8'(i * 37 + (i >> 8));
      build_program();
      run_model();
      cycle_limit = (CODE_DEPTH + exp_q.size()) * 10 * (BAUD_DIV + 1) * 12 / 10;
      wait (nrst === 1'b1);
      repeat (4) @(negedge clk);
      for (int i = 0; i < CODE_DEPTH; i++) send_uart_byte(image[i]);
      while (rx_count < exp_q.size()) @(negedge clk);
      repeat (20 * (BAUD_DIV + 1)) @(negedge clk);   // nothing more may come out
      a_all_done : assert (rx_count == exp_q.size() && wr_cnt == CODE_DEPTH)
         else log_error("byte counts differ from the expected ones at the end");
      finish_run();
   end

endmodule

//--- all.f
hdl/ice51_pkg.sv
hdl/code_loader.sv
hdl/uart_tx.sv
hdl/core_fetch.sv
hdl/core_pc.sv
hdl/core_exec.sv
hdl/ice51_top.sv
tb/tb_clk_gen.sv
tb/tb_ice51.sv
